// File: Bender.yml
package:
  name: rv_core

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/core_pkg.sv
      - exu/key_mux.sv
      - exu/alu.sv
      - exu/exu.sv
      - rtl/ifu.sv
      - rtl/idu.sv
      - rtl/gpr.sv
      - rtl/rv_core.sv
  - target: test
    include_dirs:
      - common
    files:
      - verif/rv_core_props.sv
      - verif/rv_core_tb.sv

// File: common/core_config.svh
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// data path width
`define CORE_XLEN 32

// architectural register count, x0 included
`define CORE_NREGS 32

// first fetch address out of reset
`define CORE_RESET_PC 32'h8000_0000

`endif

// File: common/core_pkg.sv
`default_nettype none

`include "core_config.svh"

package core_pkg;

	// data word, also pc and immediate
	typedef logic [`CORE_XLEN-1:0] word_t;

	// register index
	typedef logic [$clog2(`CORE_NREGS)-1:0] reg_idx_t;

	// instruction class, encoded as the major opcode itself
	typedef enum logic [6:0] {
		OP_NONE = 7'b0000000,
		OP_R    = 7'b0110011,
		OP_I    = 7'b0010011,
		OP_U    = 7'b0110111,
		OP_UPC  = 7'b0010111,
		OP_J    = 7'b1101111,
		OP_JR   = 7'b1100111
	} op_class_e;

	// alu operation
	typedef enum logic [3:0] {
		ALU_ADD    = 4'b0000,
		ALU_SUB    = 4'b1000,
		ALU_XOR    = 4'b0100,
		ALU_OR     = 4'b0110,
		ALU_AND    = 4'b0111,
		ALU_PASS_B = 4'b1111
	} alu_op_e;

	// func3 codes of the supported integer ops
	localparam logic [2:0] F3_ADDSUB = 3'b000;
	localparam logic [2:0] F3_XOR    = 3'b100;
	localparam logic [2:0] F3_OR     = 3'b110;
	localparam logic [2:0] F3_AND    = 3'b111;

endpackage

`default_nettype wire

// File: exu/alu.sv
`default_nettype none

module alu
	import core_pkg::*;
(
	input  word_t   a,
	input  word_t   b,
	input  alu_op_e op,
	output word_t   res
);

	////////////////////
	// arithmetic
	////////////////////

	// one adder, b inverted for sub
	word_t b_eff;
	logic  cin;
	word_t sum;

	assign cin   = (op == ALU_SUB);
	assign b_eff = cin ? ~b : b;
	assign sum   = a + b_eff + word_t'(cin);

	////////////////////
	// result select
	////////////////////

	always_comb begin
		case (op)
			ALU_ADD,
			ALU_SUB:    res = sum;
			ALU_XOR:    res = a ^ b;
			ALU_AND:    res = a & b;
			ALU_OR:     res = a | b;
			// lui immediate goes straight through
			ALU_PASS_B: res = b;
			default:    res = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: exu/exu.sv
`default_nettype none

module exu
	import core_pkg::*;
(
	input  logic      inst_valid,
	input  word_t     pc,
	input  word_t     imm,
	input  op_class_e op_class,
	input  reg_idx_t  rd,
	input  logic [2:0] func3,
	input  logic      func7_5,
	input  word_t     rdata1,
	input  word_t     rdata2,
	output logic      wen,
	output reg_idx_t  waddr,
	output word_t     wdata,
	output word_t     npc
);

	localparam int CLASS_W = $bits(op_class_e);

	// sequential next pc
	word_t snpc;
	assign snpc = pc + word_t'(4);

	////////////////////
	// alu operands
	////////////////////

	logic [4:0][CLASS_W-1:0] a_keys;
	word_t                   a_vals [4:0];
	logic [3:0][CLASS_W-1:0] b_keys;
	word_t                   b_vals [3:0];
	word_t                   alu_a;
	word_t                   alu_b;

	// U falls to default zero, jumps add pc+4 to zero
	assign a_keys = '{OP_R, OP_I, OP_UPC, OP_J, OP_JR};
	assign a_vals = '{rdata1, rdata1, pc, snpc, snpc};

	key_mux #(.NR_KEY(5), .KEY_LEN(CLASS_W), .payload_t(word_t)) alu_a_sel (
		.key(op_class), .default_out('0), .keys(a_keys), .values(a_vals), .out(alu_a)
	);

	// jumps fall to default zero
	assign b_keys = '{OP_R, OP_I, OP_U, OP_UPC};
	assign b_vals = '{rdata2, imm, imm, imm};

	key_mux #(.NR_KEY(4), .KEY_LEN(CLASS_W), .payload_t(word_t)) alu_b_sel (
		.key(op_class), .default_out('0), .keys(b_keys), .values(b_vals), .out(alu_b)
	);

	////////////////////
	// alu operation
	////////////////////

	logic [3:0][2:0] f3_keys;
	alu_op_e         f3_vals [3:0];
	alu_op_e         f3_op;
	alu_op_e         alu_op;

	assign f3_keys = '{F3_ADDSUB, F3_XOR, F3_OR, F3_AND};
	assign f3_vals = '{ALU_ADD, ALU_XOR, ALU_OR, ALU_AND};

	key_mux #(.NR_KEY(4), .KEY_LEN(3), .payload_t(alu_op_e)) alu_op_sel (
		.key(func3), .default_out(ALU_ADD), .keys(f3_keys), .values(f3_vals), .out(f3_op)
	);

	// func3 only means something for R and I, elsewhere it is immediate bits
	always_comb begin
		case (op_class)
			OP_R:    alu_op = (func7_5 && func3 == F3_ADDSUB) ? ALU_SUB : f3_op;
			OP_I:    alu_op = f3_op;
			OP_U:    alu_op = ALU_PASS_B;
			default: alu_op = ALU_ADD;
		endcase
	end

	alu u_alu (.a(alu_a), .b(alu_b), .op(alu_op), .res(wdata));

	////////////////////
	// next pc
	////////////////////

	logic [1:0][CLASS_W-1:0] n_keys;
	word_t                   n_vals [1:0];
	word_t                   jr_sum;

	// jalr target has bit 0 forced low
	assign jr_sum = rdata1 + imm;
	assign n_keys = '{OP_J, OP_JR};
	assign n_vals = '{pc + imm, {jr_sum[$bits(word_t)-1:1], 1'b0}};

	key_mux #(.NR_KEY(2), .KEY_LEN(CLASS_W), .payload_t(word_t)) npc_sel (
		.key(op_class), .default_out(snpc), .keys(n_keys), .values(n_vals), .out(npc)
	);

	// write back for every recognised class, gpr drops x0
	assign wen   = inst_valid && (op_class != OP_NONE);
	assign waddr = rd;

endmodule

`default_nettype wire

// File: exu/key_mux.sv
`default_nettype none

// table lookup by key, default when nothing matches
module key_mux #(
	parameter int NR_KEY = 2,
	parameter int KEY_LEN = 1,
	parameter type payload_t = logic [31:0]
) (
	input  logic [KEY_LEN-1:0]              key,
	input  payload_t                        default_out,
	input  logic [NR_KEY-1:0][KEY_LEN-1:0]  keys,
	input  payload_t                        values [NR_KEY-1:0],
	output payload_t                        out
);

	// hit vector, one bit per table entry
	logic [NR_KEY-1:0] hit;

	always_comb begin
		for (int i = 0; i < NR_KEY; i++) begin
			hit[i] = (keys[i] == key);
		end
	end

	// scan from the top so the first listed entry wins
	// keys are expected to be unique anyway
	always_comb begin
		out = default_out;
		for (int i = 0; i < NR_KEY; i++) begin
			if (hit[i]) begin
				out = values[i];
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/gpr.sv
`default_nettype none

`include "core_config.svh"

module gpr
	import core_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     wen,
	input  reg_idx_t waddr,
	input  word_t    wdata,
	input  reg_idx_t raddr1,
	input  reg_idx_t raddr2,
	output word_t    rdata1,
	output word_t    rdata2
);

	////////////////////
	// storage
	////////////////////

	word_t regs [`CORE_NREGS];

	// x0 is cleared here and never written after
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `CORE_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wen && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	////////////////////
	// read ports
	////////////////////

	// no bypass, a write shows up next cycle
	assign rdata1 = regs[raddr1];
	assign rdata2 = regs[raddr2];

endmodule

`default_nettype wire

// File: rtl/idu.sv
`default_nettype none

`include "core_config.svh"

module idu
	import core_pkg::*;
(
	input  word_t      inst,
	output op_class_e  op_class,
	output reg_idx_t   rd,
	output reg_idx_t   rs1,
	output reg_idx_t   rs2,
	output logic [2:0] func3,
	output logic       func7_5,
	output word_t      imm
);

	////////////////////
	// fixed fields
	////////////////////

	assign rd      = inst[11:7];
	assign rs1     = inst[19:15];
	assign rs2     = inst[24:20];
	assign func3   = inst[14:12];
	// add vs sub select
	assign func7_5 = inst[30];

	// opcode to class, anything unsupported becomes OP_NONE
	always_comb begin
		case (inst[6:0])
			OP_R, OP_I, OP_U, OP_UPC, OP_J, OP_JR: op_class = op_class_e'(inst[6:0]);
			default: op_class = OP_NONE;
		endcase
	end

	////////////////////
	// immediates
	////////////////////

	word_t imm_i;
	word_t imm_u;
	word_t imm_j;

	// sign bit is always inst[31]
	assign imm_i = {{(`CORE_XLEN-12){inst[31]}}, inst[31:20]};
	assign imm_u = {inst[31:12], 12'b0};
	// jal offset, scrambled bit order, lsb implied zero
	assign imm_j = {{(`CORE_XLEN-20){inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

	always_comb begin
		case (op_class)
			OP_I,
			OP_JR:   imm = imm_i;
			OP_U,
			OP_UPC:  imm = imm_u;
			OP_J:    imm = imm_j;
			// R type has no immediate
			default: imm = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: rtl/ifu.sv
`default_nettype none

`include "core_config.svh"

module ifu
	import core_pkg::*;
(
	input  logic  clk,
	input  logic  rst,
	input  logic  inst_valid,
	input  word_t npc,
	output word_t pc
);

	////////////////////
	// pc register
	////////////////////

	// holds during idle cycles
	// advances once per accepted instruction
	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= `CORE_RESET_PC;
		end else if (inst_valid) begin
			// npc already covers pc+4 and jump targets
			pc <= npc;
		end
	end

endmodule

`default_nettype wire

// File: rtl/rv_core.sv
`default_nettype none

module rv_core
	import core_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     inst_valid,
	input  word_t    inst,
	output logic     retire_valid,
	output word_t    retire_pc,
	output logic     wen,
	output reg_idx_t waddr,
	output word_t    wdata,
	output word_t    npc
);

	// fetch to decode/execute
	word_t      pc;

	// decode outputs
	op_class_e  op_class;
	reg_idx_t   rd;
	reg_idx_t   rs1;
	reg_idx_t   rs2;
	logic [2:0] func3;
	logic       func7_5;
	word_t      imm;

	// register file reads
	word_t      rdata1;
	word_t      rdata2;

	////////////////////
	// fetch
	////////////////////

	ifu u_ifu (
		.clk       (clk),
		.rst       (rst),
		.inst_valid(inst_valid),
		.npc       (npc),
		.pc        (pc)
	);

	////////////////////
	// decode
	////////////////////

	idu u_idu (
		.inst    (inst),
		.op_class(op_class),
		.rd      (rd),
		.rs1     (rs1),
		.rs2     (rs2),
		.func3   (func3),
		.func7_5 (func7_5),
		.imm     (imm)
	);

	// operands read straight off the decoded indices
	gpr u_gpr (
		.clk   (clk),
		.rst   (rst),
		.wen   (wen),
		.waddr (waddr),
		.wdata (wdata),
		.raddr1(rs1),
		.raddr2(rs2),
		.rdata1(rdata1),
		.rdata2(rdata2)
	);

	////////////////////
	// execute
	////////////////////

	exu u_exu (
		.inst_valid(inst_valid),
		.pc        (pc),
		.imm       (imm),
		.op_class  (op_class),
		.rd        (rd),
		.func3     (func3),
		.func7_5   (func7_5),
		.rdata1    (rdata1),
		.rdata2    (rdata2),
		.wen       (wen),
		.waddr     (waddr),
		.wdata     (wdata),
		.npc       (npc)
	);

	// every accepted instruction retires in the same cycle
	assign retire_valid = inst_valid;
	assign retire_pc    = pc;

endmodule

`default_nettype wire

// File: rv_core.f
+incdir+common
common/core_pkg.sv
exu/key_mux.sv
exu/alu.sv
exu/exu.sv
rtl/ifu.sv
rtl/idu.sv
rtl/gpr.sv
rtl/rv_core.sv
verif/rv_core_props.sv
verif/rv_core_tb.sv

// File: verif/rv_core_patterns.txt
// columns: inst wen waddr wdata npc, all hex, one instruction per line
// first instruction sits at the reset pc, each later one at the previous npc
12300093 1 01 00000123 80000004 // addi x1, x0, 0x123
fff00113 1 02 ffffffff 80000008 // addi x2, x0, -1
0f00c193 1 03 000001d3 8000000c // xori x3, x1, 0x0f0
5a517213 1 04 000005a5 80000010 // andi x4, x2, 0x5a5
8000e293 1 05 fffff923 80000014 // ori  x5, x1, -2048
00308333 1 06 000002f6 80000018 // add  x6, x1, x3
403083b3 1 07 ffffff50 8000001c // sub  x7, x1, x3
00514433 1 08 000006dc 80000020 // xor  x8, x2, x5
0042f4b3 1 09 00000121 80000024 // and  x9, x5, x4
0041e533 1 0a 000005f7 80000028 // or   x10, x3, x4
7ff08013 1 00 00000922 8000002c // addi x0, x1, 0x7ff
001005b3 1 0b 00000123 80000030 // add  x11, x0, x1
abcde637 1 0c abcde000 80000034 // lui  x12, 0xabcde
00001697 1 0d 80001034 80000038 // auipc x13, 0x1
0100076f 1 0e 8000003c 80000048 // jal  x14, +16
005687e7 1 0f 8000004c 80001038 // jalr x15, 5(x13)
ffc70813 1 10 80000038 8000103c // addi x16, x14, -4
410788b3 1 11 00000014 80001040 // sub  x17, x15, x16
fe1ff06f 1 00 80001044 80001020 // jal  x0, -32
7008e913 1 12 00000714 80001024 // ori  x18, x17, 0x700
00112023 0 00 00000000 80001028 // sw, not supported
00b909b3 1 13 00000837 8000102c // add  x19, x18, x11
00c04a33 1 14 abcde000 80001030 // xor  x20, x0, x12

// File: verif/rv_core_props.sv
`default_nettype none

module rv_core_props
	import core_pkg::*;
(
	input logic  clk,
	input logic  rst,
	input logic  inst_valid,
	input logic  retire_valid,
	input logic  wen,
	input word_t npc,
	input word_t pc
);

	timeunit 1ns;
	timeprecision 1ps;

	// failed assertions so far, summed into the final verdict
	int fail_cnt = 0;

	// register writes only with a retiring instruction
	wen_needs_valid: assert property (
		@(posedge clk) disable iff (rst) wen |-> retire_valid
	) else begin
		fail_cnt++;
		$error("wen high without retire_valid");
	end

	// jump targets and pc+4 are both even
	npc_even: assert property (
		@(posedge clk) disable iff (rst) !npc[0]
	) else begin
		fail_cnt++;
		$error("npc bit 0 set");
	end

	// idle cycle leaves the pc alone
	pc_holds_idle: assert property (
		@(posedge clk) disable iff (rst) !inst_valid |=> $stable(pc)
	) else begin
		fail_cnt++;
		$error("pc moved without a valid instruction");
	end

endmodule

`default_nettype wire

// File: verif/rv_core_tb.sv
`default_nettype none

`include "core_config.svh"

module rv_core_tb
	import core_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	// pattern table: inst, wen, waddr, wdata, npc per line
	localparam int NR_PAT = 23;
	localparam int NR_COL = 5;
	localparam int WATCHDOG_CYCLES = NR_PAT * 5 + 20;

	logic     clk;
	logic     rst;
	logic     inst_valid;
	word_t    inst;
	logic     retire_valid;
	word_t    retire_pc;
	logic     wen;
	reg_idx_t waddr;
	word_t    wdata;
	word_t    npc;

	logic [31:0] pat_mem [0:NR_PAT*NR_COL-1];

	int    err_cnt;
	int    check_cnt;
	// pc the next retiring instruction should carry
	word_t exp_pc;

	rv_core uut (
		.clk         (clk),
		.rst         (rst),
		.inst_valid  (inst_valid),
		.inst        (inst),
		.retire_valid(retire_valid),
		.retire_pc   (retire_pc),
		.wen         (wen),
		.waddr       (waddr),
		.wdata       (wdata),
		.npc         (npc)
	);

	bind rv_core rv_core_props u_props (
		.clk(clk), .rst(rst), .inst_valid(inst_valid), .retire_valid(retire_valid),
		.wen(wen), .npc(npc), .pc(pc)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// hard stop if the stimulus loop never gets to the end
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("run timed out after %0d cycles without reaching the end", WATCHDOG_CYCLES);
		$display("Finished with errors");
		$finish;
	end

	task automatic compare_word(input string name, input word_t got, input word_t exp,
			input int idx);
		check_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("** Error: %s = %h, expected %h (pattern %0d, t=%0t)",
				name, got, exp, idx, $time);
		end
	endtask

	////////////////////
	// one cycle each
	////////////////////

	// random garbage on inst, must be ignored
	task automatic idle_cycle(input int idx);
		@(negedge clk);
		inst_valid = 1'b0;
		inst       = $urandom;
		#1;
		compare_word("retire_valid", word_t'(retire_valid), '0, idx);
		compare_word("wen", word_t'(wen), '0, idx);
		compare_word("retire_pc", retire_pc, exp_pc, idx);
	endtask

	task automatic run_pattern(input int idx);
		word_t p_inst;
		word_t p_wen;
		word_t p_waddr;
		word_t p_wdata;
		word_t p_npc;
		p_inst  = pat_mem[idx*NR_COL];
		p_wen   = pat_mem[idx*NR_COL+1];
		p_waddr = pat_mem[idx*NR_COL+2];
		p_wdata = pat_mem[idx*NR_COL+3];
		p_npc   = pat_mem[idx*NR_COL+4];
		@(negedge clk);
		inst_valid = 1'b1;
		inst       = p_inst;
		// sampled just ahead of the rising edge
		#1;
		compare_word("retire_valid", word_t'(retire_valid), 32'h1, idx);
		compare_word("retire_pc", retire_pc, exp_pc, idx);
		compare_word("wen", word_t'(wen), p_wen, idx);
		if (p_wen != '0) begin
			compare_word("waddr", word_t'(waddr), p_waddr, idx);
			compare_word("wdata", wdata, p_wdata, idx);
		end
		compare_word("npc", npc, p_npc, idx);
		exp_pc = p_npc;
	endtask

	////////////////////
	// main sequence
	////////////////////

	initial begin
		int unsigned seed_val;
		int unsigned gap;
		err_cnt    = 0;
		check_cnt  = 0;
		rst        = 1'b1;
		inst_valid = 1'b0;
		inst       = '0;
		exp_pc     = `CORE_RESET_PC;
		seed_val   = $urandom(99936);
		$readmemh("verif/rv_core_patterns.txt", pat_mem);
		if ($isunknown(pat_mem[NR_PAT*NR_COL-1])) begin
			err_cnt++;
			$display("pattern file missing or shorter than %0d lines", NR_PAT);
		end
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		// quiet core straight out of reset
		idle_cycle(-1);
		for (int i = 0; i < NR_PAT; i++) begin
			gap = $urandom_range(3, 0);
			repeat (gap) idle_cycle(i);
			run_pattern(i);
		end
		// pc must have landed on the last npc
		idle_cycle(NR_PAT);
		$display("checks: %0d, errors: %0d, assertion failures: %0d",
			check_cnt, err_cnt, uut.u_props.fail_cnt);
		if (err_cnt == 0 && uut.u_props.fail_cnt == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

`default_nettype wire
